// File: Bender.yml
package:
  name: armaria

sources:
  - armaria_pkg.sv
  - alu.sv
  - barrel_shifter.sv
  - register_bank.sv
  - instruction_data_memory.sv
  - host_port.sv
  - control_unit.sv
  - armaria_core.sv
  - target: simulation
    files:
      - tb_armaria.sv

// File: alu.sv
`timescale 1ns/1ps

module alu #(
    parameter int DATA_WIDTH = 32
) (
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    input  armaria_pkg::opcode_e  op,
    output logic [DATA_WIDTH-1:0] result,
    output armaria_pkg::flags_t   flags
);
    localparam int MSB = DATA_WIDTH - 1;

    logic [DATA_WIDTH:0] sum;
    logic [DATA_WIDTH:0] diff;

    // Subtraction as a + ~b + 1, so the top bit is the inverted borrow
    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;

    always_comb begin
        result  = sum[MSB:0];
        flags   = '0;
        flags.c = sum[DATA_WIDTH];
        flags.v = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
        case (op)
            armaria_pkg::SUB, armaria_pkg::CMP: begin
                result  = diff[MSB:0];
                flags.c = diff[DATA_WIDTH];
                flags.v = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
            end
            armaria_pkg::AND: begin
                result  = a & b;
                flags.c = 1'b0;
                flags.v = 1'b0;
            end
            armaria_pkg::ORR: begin
                result  = a | b;
                flags.c = 1'b0;
                flags.v = 1'b0;
            end
            armaria_pkg::EOR: begin
                result  = a ^ b;
                flags.c = 1'b0;
                flags.v = 1'b0;
            end
            // ADD, ADDI and MOVI stay on the adder
            default: begin
            end
        endcase
        flags.n = result[MSB];
        flags.z = (result == '0);
    end

endmodule

// File: armaria_core.sv
`timescale 1ns/1ps

module armaria_core #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32
) (
    input  logic                                           clock,
    input  logic                                           rst,
    input  logic                                           run,
    input  logic                                           load_req,
    output logic                                           load_ack,
    input  logic [ADDR_WIDTH+armaria_pkg::INSTR_WIDTH-1:0] load_word,
    output logic                                           out_req,
    input  logic                                           out_ack,
    output logic [DATA_WIDTH-1:0]                          out_data,
    output logic                                           halted
);
    armaria_pkg::instr_t   instr;
    armaria_pkg::instr_t   imem_wdata;
    armaria_pkg::opcode_e  alu_op;
    armaria_pkg::opcode_e  shift_op;
    armaria_pkg::flags_t   alu_flags;
    armaria_pkg::flags_t   shift_flags;
    logic [ADDR_WIDTH-1:0] pc;
    logic [ADDR_WIDTH-1:0] imem_waddr;
    logic [ADDR_WIDTH-1:0] data_addr;
    logic [3:0]            rd_addr;
    logic [3:0]            ra_addr;
    logic [3:0]            rb_addr;
    logic [4:0]            shift_amount;
    logic [DATA_WIDTH-1:0] wr_data;
    logic [DATA_WIDTH-1:0] ra_data;
    logic [DATA_WIDTH-1:0] rb_data;
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] operand_b;
    logic [DATA_WIDTH-1:0] alu_result;
    logic [DATA_WIDTH-1:0] shift_result;
    logic [DATA_WIDTH-1:0] data_wdata;
    logic [DATA_WIDTH-1:0] data_rdata;
    logic [DATA_WIDTH-1:0] emit_data;
    logic                  wr_en;
    logic                  data_we;
    logic                  imem_we;
    logic                  emit_valid;
    logic                  emit_done;

    control_unit #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) control_unit_i (
        .clock, .rst, .run, .instr, .pc,
        .rd_addr, .ra_addr, .rb_addr, .wr_en, .wr_data, .ra_data, .rb_data,
        .operand_a, .operand_b, .alu_op, .alu_result, .alu_flags,
        .shift_amount, .shift_op, .shift_result, .shift_flags,
        .data_addr, .data_wdata, .data_we, .data_rdata,
        .emit_valid, .emit_data, .emit_done, .halted
    );

    register_bank #(.DATA_WIDTH(DATA_WIDTH)) register_bank_i (
        .clock, .rst, .ra_addr, .rb_addr, .rd_addr,
        .wr_en, .wr_data, .ra_data, .rb_data
    );

    alu #(.DATA_WIDTH(DATA_WIDTH)) alu_i (
        .a      (operand_a),
        .b      (operand_b),
        .op     (alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

    barrel_shifter #(.DATA_WIDTH(DATA_WIDTH)) barrel_shifter_i (
        .a      (operand_a),
        .amount (shift_amount),
        .op     (shift_op),
        .result (shift_result),
        .flags  (shift_flags)
    );

    instruction_data_memory #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) instruction_data_memory_i (
        .clock, .imem_we, .imem_waddr, .imem_wdata, .pc, .instr,
        .data_addr, .data_wdata, .data_we, .data_rdata
    );

    host_port #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) host_port_i (
        .clock, .rst, .run, .load_req, .load_ack, .load_word,
        .imem_we, .imem_waddr, .imem_wdata,
        .emit_valid, .emit_data, .emit_done,
        .out_req, .out_ack, .out_data
    );

endmodule

// File: armaria_pkg.sv
package armaria_pkg;

    localparam int INSTR_WIDTH = 16;

    // The encoding order matters: ADD through ADDI are the register-writing ops
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        ORR,
        EOR,
        LSL,
        LSR,
        ASR,
        MOVI,
        ADDI,
        LDR,
        STR,
        B,
        OUT,
        CMP,
        HALT
    } opcode_e;

    // Branch condition, carried in the rd field of a B instruction
    typedef enum logic [3:0] {
        AL = 4'd0,
        EQ = 4'd1,
        NE = 4'd2,
        LT = 4'd3,
        GE = 4'd4
    } cond_e;

    // ra and rb together double as an 8-bit immediate
    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] rd;
        logic [3:0] ra;
        logic [3:0] rb;
    } instr_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

endpackage

// File: barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter #(
    parameter int DATA_WIDTH = 32
) (
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [4:0]            amount,
    input  armaria_pkg::opcode_e  op,
    output logic [DATA_WIDTH-1:0] result,
    output armaria_pkg::flags_t   flags
);
    localparam int STAGES = 5;

    logic [DATA_WIDTH-1:0] stage [STAGES+1];
    logic                  carry [STAGES+1];
    logic                  left;
    logic                  arith;

    assign left  = (op == armaria_pkg::LSL);
    assign arith = (op == armaria_pkg::ASR);

    // Stage i shifts by 2**i, and the last active stage sets the carry
    always_comb begin
        stage[0] = a;
        carry[0] = 1'b0;
        for (int i = 0; i < STAGES; i++) begin
            stage[i+1] = stage[i];
            carry[i+1] = carry[i];
            if (amount[i]) begin
                if (left) begin
                    stage[i+1] = stage[i] << (1 << i);
                    carry[i+1] = stage[i][DATA_WIDTH - (1 << i)];
                end else begin
                    if (arith) begin
                        stage[i+1] = $signed(stage[i]) >>> (1 << i);
                    end else begin
                        stage[i+1] = stage[i] >> (1 << i);
                    end
                    carry[i+1] = stage[i][(1 << i) - 1];
                end
            end
        end
    end

    assign result  = stage[STAGES];
    assign flags.n = result[DATA_WIDTH-1];
    assign flags.z = (result == '0);
    assign flags.c = carry[STAGES];
    assign flags.v = 1'b0;

endmodule

// File: build.f
armaria_pkg.sv
alu.sv
barrel_shifter.sv
register_bank.sv
instruction_data_memory.sv
host_port.sv
control_unit.sv
armaria_core.sv
tb_armaria.sv

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  run,
    input  armaria_pkg::instr_t   instr,
    output logic [ADDR_WIDTH-1:0] pc,
    output logic [3:0]            rd_addr,
    output logic [3:0]            ra_addr,
    output logic [3:0]            rb_addr,
    output logic                  wr_en,
    output logic [DATA_WIDTH-1:0] wr_data,
    input  logic [DATA_WIDTH-1:0] ra_data,
    input  logic [DATA_WIDTH-1:0] rb_data,
    output logic [DATA_WIDTH-1:0] operand_a,
    output logic [DATA_WIDTH-1:0] operand_b,
    output armaria_pkg::opcode_e  alu_op,
    input  logic [DATA_WIDTH-1:0] alu_result,
    input  armaria_pkg::flags_t   alu_flags,
    output logic [4:0]            shift_amount,
    output armaria_pkg::opcode_e  shift_op,
    input  logic [DATA_WIDTH-1:0] shift_result,
    input  armaria_pkg::flags_t   shift_flags,
    output logic [ADDR_WIDTH-1:0] data_addr,
    output logic [DATA_WIDTH-1:0] data_wdata,
    output logic                  data_we,
    input  logic [DATA_WIDTH-1:0] data_rdata,
    output logic                  emit_valid,
    output logic [DATA_WIDTH-1:0] emit_data,
    input  logic                  emit_done,
    output logic                  halted
);
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        EXECUTE,
        MEM_WAIT,
        EMIT,
        HALTED
    } state_e;

    state_e                state;
    armaria_pkg::opcode_e  opcode;
    armaria_pkg::flags_t   flags;
    logic [DATA_WIDTH-1:0] imm;
    logic [DATA_WIDTH-1:0] exec_result;
    logic [ADDR_WIDTH-1:0] pc_plus_one;
    logic [ADDR_WIDTH-1:0] branch_target;
    logic                  is_shift;
    logic                  writes_reg;
    logic                  sets_flags;
    logic                  cond_true;
    logic                  branch_taken;

    assign opcode = instr.opcode;
    assign imm    = {{(DATA_WIDTH-8){instr.ra[3]}}, instr.ra, instr.rb};

    assign is_shift   = opcode inside {armaria_pkg::LSL, armaria_pkg::LSR, armaria_pkg::ASR};
    assign writes_reg = opcode inside {[armaria_pkg::ADD : armaria_pkg::ADDI]};
    assign sets_flags = opcode inside {[armaria_pkg::ADD : armaria_pkg::ASR], armaria_pkg::CMP};

    always_comb begin
        case (armaria_pkg::cond_e'(instr.rd))
            armaria_pkg::AL: cond_true = 1'b1;
            armaria_pkg::EQ: cond_true = flags.z;
            armaria_pkg::NE: cond_true = !flags.z;
            armaria_pkg::LT: cond_true = flags.n != flags.v;
            armaria_pkg::GE: cond_true = flags.n == flags.v;
            default:         cond_true = 1'b0;
        endcase
    end

    assign branch_taken  = (opcode == armaria_pkg::B) && cond_true;
    assign pc_plus_one   = pc + 1'b1;
    assign branch_target = pc_plus_one + imm[ADDR_WIDTH-1:0];

    // ADDI accumulates into rd, STR and OUT read rd as their data source
    assign rd_addr = instr.rd;
    assign ra_addr = (opcode == armaria_pkg::ADDI) ? instr.rd : instr.ra;
    assign rb_addr = (opcode inside {armaria_pkg::STR, armaria_pkg::OUT}) ? instr.rd : instr.rb;

    assign operand_a    = (opcode == armaria_pkg::MOVI) ? '0 : ra_data;
    assign operand_b    = (opcode inside {armaria_pkg::MOVI, armaria_pkg::ADDI}) ? imm : rb_data;
    assign alu_op       = opcode;
    assign shift_op     = opcode;
    assign shift_amount = rb_data[4:0];
    assign exec_result  = is_shift ? shift_result : alu_result;

    assign wr_en   = (state == EXECUTE && writes_reg) || (state == MEM_WAIT);
    assign wr_data = (state == MEM_WAIT) ? data_rdata : exec_result;

    assign data_addr  = ra_data[ADDR_WIDTH-1:0];
    assign data_wdata = rb_data;
    assign data_we    = (state == EXECUTE) && (opcode == armaria_pkg::STR);

    assign emit_valid = (state == EMIT);
    assign emit_data  = rb_data;
    assign halted     = (state == HALTED);

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= IDLE;
            pc    <= '0;
            flags <= '0;
        end else begin
            case (state)
                IDLE: if (run) state <= FETCH;
                FETCH: state <= EXECUTE;
                EXECUTE: begin
                    if (sets_flags) begin
                        flags <= is_shift ? shift_flags : alu_flags;
                    end
                    case (opcode)
                        armaria_pkg::LDR:  state <= MEM_WAIT;
                        armaria_pkg::OUT:  state <= EMIT;
                        armaria_pkg::HALT: state <= HALTED;
                        default: begin
                            state <= FETCH;
                            pc    <= branch_taken ? branch_target : pc_plus_one;
                        end
                    endcase
                end
                MEM_WAIT: begin
                    state <= FETCH;
                    pc    <= pc_plus_one;
                end
                EMIT: begin
                    if (emit_done) begin
                        state <= FETCH;
                        pc    <= pc_plus_one;
                    end
                end
                HALTED: state <= HALTED;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: host_port.sv
`timescale 1ns/1ps

module host_port #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32
) (
    input  logic                                        clock,
    input  logic                                        rst,
    input  logic                                        run,
    input  logic                                        load_req,
    output logic                                        load_ack,
    input  logic [ADDR_WIDTH+armaria_pkg::INSTR_WIDTH-1:0] load_word,
    output logic                                        imem_we,
    output logic [ADDR_WIDTH-1:0]                       imem_waddr,
    output armaria_pkg::instr_t                         imem_wdata,
    input  logic                                        emit_valid,
    input  logic [DATA_WIDTH-1:0]                       emit_data,
    output logic                                        emit_done,
    output logic                                        out_req,
    input  logic                                        out_ack,
    output logic [DATA_WIDTH-1:0]                       out_data
);
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        armaria_pkg::instr_t   instr;
    } load_word_t;

    typedef enum logic [1:0] {
        OUT_IDLE,
        OUT_REQ,
        OUT_ACK,
        OUT_DONE
    } out_state_e;

    load_word_t load_q;
    out_state_e out_state;

    // load_ack doubles as the receiver state, so each request writes once
    always_ff @(posedge clock) begin
        if (rst) begin
            load_ack <= 1'b0;
            imem_we  <= 1'b0;
        end else begin
            imem_we <= 1'b0;
            if (!load_ack) begin
                if (load_req && !run) begin
                    load_ack <= 1'b1;
                    imem_we  <= 1'b1;
                end
            end else if (!load_req) begin
                load_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!load_ack && load_req) begin
            load_q <= load_word;
        end
    end

    assign imem_waddr = load_q.addr;
    assign imem_wdata = load_q.instr;

    always_ff @(posedge clock) begin
        if (rst) begin
            out_state <= OUT_IDLE;
        end else begin
            case (out_state)
                OUT_IDLE: if (emit_valid) out_state <= OUT_REQ;
                OUT_REQ:  if (out_ack) out_state <= OUT_ACK;
                OUT_ACK:  if (!out_ack) out_state <= OUT_DONE;
                default:  out_state <= OUT_IDLE;
            endcase
        end
    end

    // Captured once per OUT, the core holds emit_valid until emit_done
    always_ff @(posedge clock) begin
        if (out_state == OUT_IDLE && emit_valid) begin
            out_data <= emit_data;
        end
    end

    assign out_req   = (out_state == OUT_REQ);
    assign emit_done = (out_state == OUT_DONE);

endmodule

// File: instruction_data_memory.sv
`timescale 1ns/1ps

module instruction_data_memory #(
    parameter int ADDR_WIDTH = 8,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clock,
    input  logic                  imem_we,
    input  logic [ADDR_WIDTH-1:0] imem_waddr,
    input  armaria_pkg::instr_t   imem_wdata,
    input  logic [ADDR_WIDTH-1:0] pc,
    output armaria_pkg::instr_t   instr,
    input  logic [ADDR_WIDTH-1:0] data_addr,
    input  logic [DATA_WIDTH-1:0] data_wdata,
    input  logic                  data_we,
    output logic [DATA_WIDTH-1:0] data_rdata
);
    localparam int DEPTH = 2 ** ADDR_WIDTH;

    armaria_pkg::instr_t   imem [DEPTH];
    logic [DATA_WIDTH-1:0] dmem [DEPTH];

    // Program store, written only by the host port
    always_ff @(posedge clock) begin
        if (imem_we) begin
            imem[imem_waddr] <= imem_wdata;
        end
        instr <= imem[pc];
    end

    // Single port, read returns the old contents on a write
    always_ff @(posedge clock) begin
        if (data_we) begin
            dmem[data_addr] <= data_wdata;
        end
        data_rdata <= dmem[data_addr];
    end

endmodule

// File: register_bank.sv
`timescale 1ns/1ps

module register_bank #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic [3:0]            ra_addr,
    input  logic [3:0]            rb_addr,
    input  logic [3:0]            rd_addr,
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic [DATA_WIDTH-1:0] ra_data,
    output logic [DATA_WIDTH-1:0] rb_data
);
    logic [DATA_WIDTH-1:0] regs [16];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_addr] <= wr_data;
        end
    end

    // Reads see the old value during the write cycle
    assign ra_data = regs[ra_addr];
    assign rb_data = regs[rb_addr];

endmodule

// File: tb_armaria.sv
`timescale 1ns/1ps

module tb_armaria;

    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 32;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        armaria_pkg::instr_t   instr;
    } load_word_t;

    logic                  clock;
    logic                  rst;
    logic                  run;
    logic                  load_req;
    logic                  load_ack;
    load_word_t            load_word;
    logic                  out_req;
    logic                  out_ack;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  halted;

    armaria_pkg::instr_t   prog [$];
    logic [DATA_WIDTH-1:0] exp_q [$];
    logic [DATA_WIDTH-1:0] got_q [$];
    int                    errors = 0;
    int                    checks = 0;
    int                    tests = 0;
    int                    errors_before = 0;
    int                    cycle_count = 0;
    int                    cycle_limit = 0;

    armaria_core #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) armaria_core_i (
        .clock, .rst, .run, .load_req, .load_ack, .load_word,
        .out_req, .out_ack, .out_data, .halted
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("The run timed out after %0d cycles before the tests were done",
                     cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Host side of the OUT handshake waits a random number of cycles before each ack
    always @(posedge clock) begin : answer_out_req
        int delay;
        #0.5;
        if (out_req && !out_ack) begin
            got_q.push_back(out_data);
            delay = $urandom_range(3, 0);
            repeat (delay) begin
                @(posedge clock);
                #0.5;
            end
            out_ack = 1'b1;
            do begin
                @(posedge clock);
                #0.5;
            end while (out_req);
            out_ack = 1'b0;
        end
    end

    always @(posedge clock) begin : compare_outputs
        logic [DATA_WIDTH-1:0] got;
        logic [DATA_WIDTH-1:0] expected;
        while (got_q.size() > 0) begin
            got = got_q.pop_front();
            checks++;
            assert (exp_q.size() > 0) else begin
                $display("OUT value %h arrived after all expected values were used up", got);
                errors++;
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                assert (got == expected) else begin
                    $display("CHECK FAILED: out_data expected %h got %h", expected, got);
                    errors++;
                end
            end
        end
    end

    // Executes prog on a model of the core, fills exp_q and returns the instruction count
    function automatic int run_reference();
        logic [DATA_WIDTH-1:0] regs [16];
        logic [DATA_WIDTH-1:0] dmem [256];
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] r;
        logic [DATA_WIDTH-1:0] imm;
        logic [1:0]            cv;
        logic [7:0]            pc;
        logic                  take;
        armaria_pkg::flags_t   fl;
        armaria_pkg::instr_t   ins;
        int                    k;
        int                    steps;
        bit                    done;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc = '0;
        fl = '0;
        steps = 0;
        done = 0;
        exp_q.delete();
        while (!done && steps < 2000) begin
            ins = prog[pc];
            a = regs[ins.ra];
            b = regs[ins.rb];
            imm = {{24{ins.ra[3]}}, ins.ra, ins.rb};
            k = b[4:0];
            r = '0;
            cv = 2'b00;
            steps++;
            pc = pc + 8'd1;
            case (ins.opcode)
                armaria_pkg::ADD: begin
                    r = a + b;
                    cv = {r < a, (a[31] == b[31]) && (r[31] != a[31])};
                end
                armaria_pkg::SUB, armaria_pkg::CMP: begin
                    r = a - b;
                    cv = {a >= b, (a[31] != b[31]) && (r[31] != a[31])};
                end
                armaria_pkg::AND: r = a & b;
                armaria_pkg::ORR: r = a | b;
                armaria_pkg::EOR: r = a ^ b;
                armaria_pkg::LSL: begin
                    r = a << k;
                    cv = {(k != 0) ? a[32 - k] : 1'b0, 1'b0};
                end
                armaria_pkg::LSR: begin
                    r = a >> k;
                    cv = {(k != 0) ? a[k - 1] : 1'b0, 1'b0};
                end
                armaria_pkg::ASR: begin
                    r = $signed(a) >>> k;
                    cv = {(k != 0) ? a[k - 1] : 1'b0, 1'b0};
                end
                armaria_pkg::MOVI: r = imm;
                armaria_pkg::ADDI: r = regs[ins.rd] + imm;
                armaria_pkg::LDR:  r = dmem[a[7:0]];
                armaria_pkg::STR:  dmem[a[7:0]] = regs[ins.rd];
                armaria_pkg::OUT:  exp_q.push_back(regs[ins.rd]);
                armaria_pkg::HALT: done = 1;
                armaria_pkg::B: begin
                    case (armaria_pkg::cond_e'(ins.rd))
                        armaria_pkg::AL: take = 1'b1;
                        armaria_pkg::EQ: take = fl.z;
                        armaria_pkg::NE: take = !fl.z;
                        armaria_pkg::LT: take = fl.n != fl.v;
                        armaria_pkg::GE: take = fl.n == fl.v;
                        default:         take = 1'b0;
                    endcase
                    if (take) begin
                        pc = pc + imm[7:0];
                    end
                end
                default: begin
                end
            endcase
            if (ins.opcode inside {[armaria_pkg::ADD : armaria_pkg::ASR], armaria_pkg::CMP}) begin
                fl = {r[31], r == '0, cv};
            end
            if (ins.opcode inside {[armaria_pkg::ADD : armaria_pkg::ADDI], armaria_pkg::LDR}) begin
                regs[ins.rd] = r;
            end
        end
        return steps;
    endfunction

    task automatic append_op(input armaria_pkg::opcode_e op, input logic [3:0] rd,
                             input logic [3:0] ra, input logic [3:0] rb);
        armaria_pkg::instr_t ins;
        ins = {op, rd, ra, rb};
        prog.push_back(ins);
    endtask

    task automatic append_imm(input armaria_pkg::opcode_e op, input logic [3:0] rd,
                              input logic [7:0] imm);
        append_op(op, rd, imm[7:4], imm[3:0]);
    endtask

    // Resets the core, loads prog word by word, runs it and waits for HALT
    task automatic run_program();
        int steps;
        steps = run_reference();
        cycle_limit += 20 * steps + 50;
        got_q.delete();
        run = 1'b0;
        rst = 1'b1;
        repeat (5) @(posedge clock);
        #0.5;
        rst = 1'b0;
        foreach (prog[i]) begin
            load_word.addr = ADDR_WIDTH'(i);
            load_word.instr = prog[i];
            load_req = 1'b1;
            do begin
                @(posedge clock);
                #0.5;
            end while (!load_ack);
            load_req = 1'b0;
            do begin
                @(posedge clock);
                #0.5;
            end while (load_ack);
        end
        run = 1'b1;
        do begin
            @(posedge clock);
            #0.5;
        end while (!halted);
        repeat (2) @(posedge clock);
        #0.5;
    endtask

    task automatic report_test(input string name);
        assert (exp_q.size() == 0) else begin
            $display("Test %s never received %0d expected OUT values", name, exp_q.size());
            errors += exp_q.size();
        end
        exp_q.delete();
        tests++;
        $display("Test %0d (%s) finished with %0d errors", tests, name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic arith_logic_test();
        armaria_pkg::opcode_e ops [5] = '{armaria_pkg::ADD, armaria_pkg::SUB, armaria_pkg::AND,
                                          armaria_pkg::ORR, armaria_pkg::EOR};
        prog.delete();
        for (int i = 1; i <= 4; i++) begin
            append_imm(armaria_pkg::MOVI, 4'(i), 8'($urandom));
            append_imm(armaria_pkg::ADDI, 4'(i), 8'($urandom));
        end
        // One operand gets wide so carries reach the top bit
        append_imm(armaria_pkg::MOVI, 6, 8'd24);
        append_op(armaria_pkg::LSL, 4, 4, 6);
        for (int i = 0; i < 10; i++) begin
            append_op(ops[i % 5], 5, 4'($urandom_range(4, 1)), 4'($urandom_range(4, 1)));
            append_op(armaria_pkg::OUT, 5, 0, 0);
        end
        append_op(armaria_pkg::HALT, 0, 0, 0);
        run_program();
        report_test("arithmetic and logic");
    endtask

    task automatic shift_test();
        armaria_pkg::opcode_e ops [3] = '{armaria_pkg::LSL, armaria_pkg::LSR, armaria_pkg::ASR};
        prog.delete();
        // r1 is negative and r2 is a wide positive value
        append_imm(armaria_pkg::MOVI, 1, 8'($urandom) | 8'h80);
        append_imm(armaria_pkg::ADDI, 1, 8'($urandom) | 8'h80);
        append_imm(armaria_pkg::MOVI, 6, 8'd20);
        append_imm(armaria_pkg::MOVI, 2, 8'($urandom) & 8'h7f);
        append_op(armaria_pkg::LSL, 2, 2, 6);
        append_imm(armaria_pkg::ADDI, 2, 8'($urandom) & 8'h7f);
        append_imm(armaria_pkg::MOVI, 7, 8'd0);
        append_imm(armaria_pkg::MOVI, 8, 8'd31);
        append_imm(armaria_pkg::MOVI, 9, 8'($urandom_range(30, 1)));
        append_imm(armaria_pkg::MOVI, 10, 8'($urandom_range(30, 1)));
        foreach (ops[i]) begin
            for (int src = 1; src <= 2; src++) begin
                for (int amt = 7; amt <= 10; amt++) begin
                    append_op(ops[i], 5, 4'(src), 4'(amt));
                    append_op(armaria_pkg::OUT, 5, 0, 0);
                end
            end
        end
        append_op(armaria_pkg::HALT, 0, 0, 0);
        run_program();
        report_test("shifts");
    endtask

    task automatic branch_test();
        armaria_pkg::cond_e conds [4] = '{armaria_pkg::EQ, armaria_pkg::NE, armaria_pkg::LT,
                                          armaria_pkg::GE};
        logic [7:0]         x;
        prog.delete();
        for (int i = 0; i < 8; i++) begin
            x = 8'($urandom);
            append_imm(armaria_pkg::MOVI, 1, x);
            append_imm(armaria_pkg::MOVI, 2, (i % 3 == 0) ? x : 8'($urandom));
            append_op(armaria_pkg::CMP, 0, 1, 2);
            append_imm(armaria_pkg::B, conds[i % 4], 8'd3);
            append_imm(armaria_pkg::MOVI, 3, 8'(2 * i));
            append_op(armaria_pkg::OUT, 3, 0, 0);
            append_imm(armaria_pkg::B, armaria_pkg::AL, 8'd2);
            append_imm(armaria_pkg::MOVI, 3, 8'(2 * i + 1));
            append_op(armaria_pkg::OUT, 3, 0, 0);
        end
        // Countdown loop where the branch goes back to the OUT three words before it
        append_imm(armaria_pkg::MOVI, 4, 8'($urandom_range(6, 3)));
        append_imm(armaria_pkg::MOVI, 5, 8'd0);
        append_op(armaria_pkg::OUT, 4, 0, 0);
        append_imm(armaria_pkg::ADDI, 4, 8'hff);
        append_op(armaria_pkg::CMP, 0, 4, 5);
        append_imm(armaria_pkg::B, armaria_pkg::NE, 8'hfc);
        append_op(armaria_pkg::HALT, 0, 0, 0);
        run_program();
        report_test("flags and branches");
    endtask

    task automatic memory_test();
        int         order [6];
        int         j;
        int         t;
        logic [7:0] base;
        prog.delete();
        base = 8'($urandom);
        append_imm(armaria_pkg::MOVI, 13, 8'd16);
        for (int i = 0; i < 6; i++) begin
            append_imm(armaria_pkg::MOVI, 4'(1 + i), 8'($urandom));
            append_op(armaria_pkg::LSL, 4'(1 + i), 4'(1 + i), 13);
            append_imm(armaria_pkg::ADDI, 4'(1 + i), 8'($urandom));
            append_imm(armaria_pkg::MOVI, 4'(7 + i), base + 8'(41 * i));
            append_op(armaria_pkg::STR, 4'(1 + i), 4'(7 + i), 0);
            order[i] = i;
        end
        for (int i = 5; i > 0; i--) begin
            j = $urandom_range(i, 0);
            t = order[j];
            order[j] = order[i];
            order[i] = t;
        end
        foreach (order[i]) begin
            append_op(armaria_pkg::LDR, 14, 4'(7 + order[i]), 0);
            append_op(armaria_pkg::OUT, 14, 0, 0);
        end
        append_op(armaria_pkg::HALT, 0, 0, 0);
        run_program();
        report_test("memory");
    endtask

    task automatic handshake_halt_test();
        prog.delete();
        append_imm(armaria_pkg::MOVI, 1, 8'($urandom));
        for (int i = 0; i < 16; i++) begin
            append_op(armaria_pkg::OUT, 1, 0, 0);
            append_imm(armaria_pkg::ADDI, 1, 8'd1);
        end
        append_op(armaria_pkg::HALT, 0, 0, 0);
        run_program();
        repeat (10) begin
            checks++;
            assert (halted && !out_req) else begin
                $display("The core left HALTED or raised out_req after HALT");
                errors++;
            end
            @(posedge clock);
            #0.5;
        end
        // run is still high, so this request must go unanswered
        load_word = '0;
        load_req = 1'b1;
        repeat (10) begin
            @(posedge clock);
            #0.5;
            checks++;
            assert (!load_ack) else begin
                $display("load_ack answered a load request while run was high");
                errors++;
            end
        end
        load_req = 1'b0;
        report_test("handshakes and halt");
    endtask

    initial begin
        void'($urandom(10));
        clock = 1'b0;
        rst = 1'b1;
        run = 1'b0;
        load_req = 1'b0;
        load_word = '0;
        out_ack = 1'b0;
        arith_logic_test();
        shift_test();
        branch_test();
        memory_test();
        handshake_halt_test();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
